//--- hdl/l2_dbg_cfg.svh
// Sizing macros for the L2 debug-bus subsystem
// Included by every RTL and bench file that sizes a bus or a counter
// A debug bus is `L2_DBG_DATA_W + 1 bits, valid on top

`ifndef L2_DBG_CFG_SVH
`define L2_DBG_CFG_SVH

// Debug word data width, valid bit sits just above it
`define L2_DBG_DATA_W 40

// Payload field below the bank index and the mode code
`define L2_DBG_PAY_W (`L2_DBG_DATA_W - 4)

// Bank count, the repeater tree is built for exactly four
`define L2_DBG_NBANK 4

// Bank event address width
`define L2_DBG_EVT_W 32

// Per-bank event counter and capture drop counter, both saturate
`define L2_DBG_CNT_W 16

`endif

//--- hdl/l2_dbg_pkg.sv
// Shared types for the L2 debug-bus subsystem
// Holds the debug mode and the capture handshake states
// Modules name these types in their headers and import the rest in the body

package l2_dbg_pkg;

  // Debug mode, shared by all bank formatters
  // The code also lands in bits 37:36 of every debug word
  typedef enum logic [1:0] {
    // No words produced
    MODE_OFF   = 2'd0,
    // Event address in the payload
    MODE_ADDR  = 2'd1,
    // Hit flag in bit 35, address below it
    MODE_HIT   = 2'd2,
    // Running event count after this event
    MODE_COUNT = 2'd3
  } dbg_mode_e;

  // Capture block states for the four-phase host handshake
  typedef enum logic [1:0] {
    // Empty, a valid root word is loaded here
    CAP_IDLE = 2'd0,
    // Word owned, req high, waiting for ack
    CAP_REQ  = 2'd1,
    // Req dropped, waiting for the host to drop ack
    CAP_REL  = 2'd2
  } cap_state_e;

  // Encoding 2'd3 of cap_state_e is unused
  // The capture FSM returns to CAP_IDLE from it

endpackage

//--- hdl/dbg_word_fmt.sv
// Per-bank debug word formatter
// Turns one bank event strobe into one registered 41-bit debug word
// Layout is bank index in 39:38, mode code in 37:36, payload in 35:0
// One instance per bank, bank_id tied at the top level

`timescale 1ns/1ps

`include "l2_dbg_cfg.svh"

module dbg_word_fmt (
  input  logic                                rclk,
  input  logic                                rst_n,
  input  logic [$clog2(`L2_DBG_NBANK)-1:0]    bank_id,
  input  l2_dbg_pkg::dbg_mode_e               mode,
  input  logic                                evt,
  input  logic [`L2_DBG_EVT_W-1:0]            addr,
  input  logic                                hit,
  output logic [`L2_DBG_DATA_W:0]             dbgbus
);

  import l2_dbg_pkg::*;

  // Zero padding between the source fields and the payload width
  localparam int ADDR_PAD = `L2_DBG_PAY_W - `L2_DBG_EVT_W;
  localparam int HIT_PAD  = `L2_DBG_PAY_W - 1 - `L2_DBG_EVT_W;
  localparam int CNT_PAD  = `L2_DBG_PAY_W - `L2_DBG_CNT_W;

  // Running event count, value after the current event
  logic [`L2_DBG_CNT_W-1:0]  cnt_q;
  logic [`L2_DBG_CNT_W-1:0]  cnt_nxt;

  // An event only counts and only makes a word when tracing is on
  logic                      evt_act;

  // Payload and full word before the register
  logic [`L2_DBG_PAY_W-1:0]  payload;
  logic [`L2_DBG_DATA_W-1:0] word_d;

  // Registered word and its valid bit
  logic [`L2_DBG_DATA_W-1:0] word_q;
  logic                      vld_q;

  assign evt_act = evt && (mode != MODE_OFF);

  // Saturate at all ones
  always_comb begin
    if (cnt_q == {`L2_DBG_CNT_W{1'b1}}) begin
      cnt_nxt = cnt_q;
    end else begin
      cnt_nxt = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (evt_act) begin
      cnt_q <= cnt_nxt;
    end
  end

  // Mode decode into the payload field
  always_comb begin
    case (mode)
      MODE_ADDR: begin
        payload = {{ADDR_PAD{1'b0}}, addr};
      end
      MODE_HIT: begin
        // Hit flag on the top payload bit
        payload = {hit, {HIT_PAD{1'b0}}, addr};
      end
      MODE_COUNT: begin
        payload = {{CNT_PAD{1'b0}}, cnt_nxt};
      end
      default: begin
        payload = '0;
      end
    endcase
  end

  // Bank index, then mode code, then payload
  assign word_d = {bank_id, mode, payload};

  // Valid for exactly one cycle per active event
  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= evt_act;
    end
  end

  // Word data holds its last value between events
  always_ff @(posedge rclk) begin
    if (evt_act) begin
      word_q <= word_d;
    end
  end

  assign dbgbus = {vld_q, word_q};

endmodule

//--- hdl/dbg_rptr.sv
// Registered 2:1 debug-bus repeater
// Input 0 wins whenever its valid bit is set, input 1 is lost that cycle
// Output valid is the OR of both input valid bits, one cycle later

`timescale 1ns/1ps

`include "l2_dbg_cfg.svh"

module dbg_rptr (
  input  logic                      rclk,
  input  logic                      rst_n,
  input  logic [`L2_DBG_DATA_W:0]   dbgbus_b0,
  input  logic [`L2_DBG_DATA_W:0]   dbgbus_b1,
  output logic [`L2_DBG_DATA_W:0]   dbgbus_out
);

  // Selected data before the flop
  logic [`L2_DBG_DATA_W-1:0] data_d;
  logic                      vld_d;

  // Repeater stage registers
  logic [`L2_DBG_DATA_W-1:0] data_q;
  logic                      vld_q;

  // Priority mux on the b0 valid bit
  assign data_d = dbgbus_b0[`L2_DBG_DATA_W] ? dbgbus_b0[`L2_DBG_DATA_W-1:0]
                                            : dbgbus_b1[`L2_DBG_DATA_W-1:0];

  // Valid merge, a collision still yields one valid word
  assign vld_d = dbgbus_b0[`L2_DBG_DATA_W] | dbgbus_b1[`L2_DBG_DATA_W];

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= vld_d;
    end
  end

  // Data flops load every cycle, qualified downstream by valid
  always_ff @(posedge rclk) begin
    data_q <= data_d;
  end

  assign dbgbus_out = {vld_q, data_q};

endmodule

//--- hdl/dbg_capture.sv
// Root capture block for the debug-bus tree
// Holds one debug word and offers it to the host with a four-phase req/ack
// Words arriving while a word is owned are dropped and counted
// dbg_req rises at the edge that loads the word

`timescale 1ns/1ps

`include "l2_dbg_cfg.svh"

module dbg_capture (
  input  logic                        rclk,
  input  logic                        rst_n,
  input  logic [`L2_DBG_DATA_W:0]     dbgbus,
  input  logic                        dbg_ack,
  output logic                        dbg_req,
  output logic [`L2_DBG_DATA_W-1:0]   dbg_data,
  output logic [`L2_DBG_CNT_W-1:0]    dbg_drop_cnt
);

  import l2_dbg_pkg::*;

  cap_state_e                state_q;
  cap_state_e                state_d;

  // Root word valid bit
  logic                      bus_vld;

  // Load into the holding register, or lose the word
  logic                      load;
  logic                      drop;

  // Owned word, stable from load until the next load
  logic [`L2_DBG_DATA_W-1:0] data_q;

  logic [`L2_DBG_CNT_W-1:0]  drop_q;

  assign bus_vld = dbgbus[`L2_DBG_DATA_W];

  // Only an idle capture takes a word
  assign load = bus_vld && (state_q == CAP_IDLE);
  assign drop = bus_vld && (state_q != CAP_IDLE);

  // Four-phase handshake FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      CAP_IDLE: begin
        if (load) begin
          state_d = CAP_REQ;
        end
      end
      CAP_REQ: begin
        // Host has the word, drop req
        if (dbg_ack) begin
          state_d = CAP_REL;
        end
      end
      CAP_REL: begin
        // Wait out the host's ack release before the next word
        if (!dbg_ack) begin
          state_d = CAP_IDLE;
        end
      end
      default: begin
        state_d = CAP_IDLE;
      end
    endcase
  end

  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= CAP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Req straight off the state register, no combinational path from ack
  assign dbg_req = (state_q == CAP_REQ);

  // Holding register, written only on load
  always_ff @(posedge rclk) begin
    if (load) begin
      data_q <= dbgbus[`L2_DBG_DATA_W-1:0];
    end
  end

  assign dbg_data = data_q;

  // Drop counter, saturates at all ones
  always_ff @(posedge rclk or negedge rst_n) begin
    if (!rst_n) begin
      drop_q <= '0;
    end else if (drop && (drop_q != {`L2_DBG_CNT_W{1'b1}})) begin
      drop_q <= drop_q + 1'b1;
    end
  end

  assign dbg_drop_cnt = drop_q;

endmodule

//--- hdl/l2_dbg_top.sv
// Top level of the L2 debug-bus subsystem
// Four bank formatters feed a two-level repeater tree into one capture block
// Bank pairs (0,1) and (2,3) merge first, pair (0,1) has priority at the root
// Event to dbg_req is four edges when capture is idle

`timescale 1ns/1ps

`include "l2_dbg_cfg.svh"

module l2_dbg_top (
  input  logic                        rclk,
  input  logic                        rst_n,
  input  l2_dbg_pkg::dbg_mode_e       dbg_mode,
  // Bank 0 events
  input  logic                        bank_evt_0,
  input  logic [`L2_DBG_EVT_W-1:0]    bank_addr_0,
  input  logic                        bank_hit_0,
  // Bank 1 events
  input  logic                        bank_evt_1,
  input  logic [`L2_DBG_EVT_W-1:0]    bank_addr_1,
  input  logic                        bank_hit_1,
  // Bank 2 events
  input  logic                        bank_evt_2,
  input  logic [`L2_DBG_EVT_W-1:0]    bank_addr_2,
  input  logic                        bank_hit_2,
  // Bank 3 events
  input  logic                        bank_evt_3,
  input  logic [`L2_DBG_EVT_W-1:0]    bank_addr_3,
  input  logic                        bank_hit_3,
  // Debug host side
  input  logic                        dbg_ack,
  output logic                        dbg_req,
  output logic [`L2_DBG_DATA_W-1:0]   dbg_data,
  output logic [`L2_DBG_CNT_W-1:0]    dbg_drop_cnt
);

  // Bank formatter buses
  logic [`L2_DBG_DATA_W:0] bus_b0;
  logic [`L2_DBG_DATA_W:0] bus_b1;
  logic [`L2_DBG_DATA_W:0] bus_b2;
  logic [`L2_DBG_DATA_W:0] bus_b3;

  // First repeater level
  logic [`L2_DBG_DATA_W:0] bus_01;
  logic [`L2_DBG_DATA_W:0] bus_23;

  // Root of the tree
  logic [`L2_DBG_DATA_W:0] bus_root;

  dbg_word_fmt i_fmt_0 (
    .rclk(rclk), .rst_n(rst_n), .bank_id(2'd0), .mode(dbg_mode),
    .evt(bank_evt_0), .addr(bank_addr_0), .hit(bank_hit_0), .dbgbus(bus_b0)
  );

  dbg_word_fmt i_fmt_1 (
    .rclk(rclk), .rst_n(rst_n), .bank_id(2'd1), .mode(dbg_mode),
    .evt(bank_evt_1), .addr(bank_addr_1), .hit(bank_hit_1), .dbgbus(bus_b1)
  );

  dbg_word_fmt i_fmt_2 (
    .rclk(rclk), .rst_n(rst_n), .bank_id(2'd2), .mode(dbg_mode),
    .evt(bank_evt_2), .addr(bank_addr_2), .hit(bank_hit_2), .dbgbus(bus_b2)
  );

  dbg_word_fmt i_fmt_3 (
    .rclk(rclk), .rst_n(rst_n), .bank_id(2'd3), .mode(dbg_mode),
    .evt(bank_evt_3), .addr(bank_addr_3), .hit(bank_hit_3), .dbgbus(bus_b3)
  );

  // Lower bank wins in each pair
  dbg_rptr i_rptr_01 (
    .rclk(rclk), .rst_n(rst_n),
    .dbgbus_b0(bus_b0), .dbgbus_b1(bus_b1), .dbgbus_out(bus_01)
  );

  dbg_rptr i_rptr_23 (
    .rclk(rclk), .rst_n(rst_n),
    .dbgbus_b0(bus_b2), .dbgbus_b1(bus_b3), .dbgbus_out(bus_23)
  );

  dbg_rptr i_rptr_root (
    .rclk(rclk), .rst_n(rst_n),
    .dbgbus_b0(bus_01), .dbgbus_b1(bus_23), .dbgbus_out(bus_root)
  );

  dbg_capture i_capture (
    .rclk(rclk), .rst_n(rst_n), .dbgbus(bus_root), .dbg_ack(dbg_ack),
    .dbg_req(dbg_req), .dbg_data(dbg_data), .dbg_drop_cnt(dbg_drop_cnt)
  );

endmodule

//--- bench/l2_dbg_properties.sv
// Handshake assertions for the L2 debug-bus top level
// Bound into every l2_dbg_top, watches the host side and the root bus valid
// A failed property raises $error and bumps fail_cnt

`timescale 1ns/1ps

`include "l2_dbg_cfg.svh"

module l2_dbg_properties (
  input logic                      rclk,
  input logic                      rst_n,
  input logic                      dbg_req,
  input logic                      dbg_ack,
  input logic [`L2_DBG_DATA_W-1:0] dbg_data,
  input logic                      root_vld
);

  // Number of property failures so far
  int fail_cnt = 0;

  // Req held until the host acknowledges
  req_hold: assert property (@(posedge rclk) disable iff (!rst_n)
    dbg_req && !dbg_ack |=> dbg_req)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("dbg_req dropped before dbg_ack was seen");
    end

  // Owned word must not move under the host
  data_stable: assert property (@(posedge rclk) disable iff (!rst_n)
    dbg_req && $past(dbg_req) |-> $stable(dbg_data))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("dbg_data changed while dbg_req was high");
    end

  // New req only once the previous ack is gone
  no_rise_on_ack: assert property (@(posedge rclk) disable iff (!rst_n)
    $rose(dbg_req) |-> !$past(dbg_ack))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("dbg_req rose while dbg_ack was still high");
    end

  // No word at the root, no req
  req_needs_word: assert property (@(posedge rclk) disable iff (!rst_n)
    !dbg_req && !root_vld |=> !dbg_req)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("dbg_req rose without a valid root word");
    end

endmodule

// Attach to every l2_dbg_top instance
bind l2_dbg_top l2_dbg_properties i_l2_dbg_props (
  .rclk(rclk), .rst_n(rst_n), .dbg_req(dbg_req), .dbg_ack(dbg_ack),
  .dbg_data(dbg_data), .root_vld(bus_root[`L2_DBG_DATA_W])
);

//--- bench/l2_dbg_tb.sv
// Testbench for the L2 debug-bus subsystem
// Drives bank events through l2_dbg_top, answers the host handshake
// with random delays and checks every delivered word against a scoreboard
// Runs counter, single event, mode off, priority and back-pressure tests

`timescale 1ns/1ps

`include "l2_dbg_cfg.svh"

module l2_dbg_tb;

  import l2_dbg_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DRV_DLY    = 5;
  localparam int RST_CYCLES = 5;
  localparam logic [31:0] LFSR_SEED = 32'h3f13_0560;
  // Galois taps, x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // Test lengths in words or cycles
  localparam int N_COUNT  = 4;
  localparam int N_SINGLE = 3 * `L2_DBG_NBANK;
  localparam int N_PRIO   = 6;
  localparam int N_BURST  = 3;
  localparam int OFF_CYC  = 12;
  // Worst case per word: path, two slow host phases, back to idle
  localparam int WORD_CYC = 16;
  localparam int MARGIN   = 100;
  localparam int WDOG_NS  = (RST_CYCLES + OFF_CYC + MARGIN
                            + WORD_CYC * (N_COUNT + N_SINGLE + N_PRIO + N_BURST)) * CLK_PERIOD;
  localparam logic [3:0] PRIO_MASKS [N_PRIO] = '{4'b0011, 4'b1100, 4'b0110,
                                                 4'b1010, 4'b1110, 4'b1111};

  logic                      rclk;
  logic                      rst_n;
  dbg_mode_e                 dbg_mode;
  logic [3:0]                evt;
  logic [`L2_DBG_EVT_W-1:0]  addr [4];
  logic [3:0]                hit;
  logic                      dbg_ack;
  logic                      dbg_req;
  logic [`L2_DBG_DATA_W-1:0] dbg_data;
  logic [`L2_DBG_CNT_W-1:0]  dbg_drop_cnt;

  // Separate LFSR states for stimulus and host
  logic [31:0]               stim_lfsr = LFSR_SEED;
  logic [31:0]               host_lfsr = LFSR_SEED;
  // Expected words in delivery order
  logic [`L2_DBG_DATA_W-1:0] exp_q [$];
  // Model of each bank's event counter
  logic [`L2_DBG_CNT_W-1:0]  bank_cnt [4] = '{default: '0};
  string                     test_name = "reset";
  int                        mismatch_cnt = 0;
  int                        other_err_cnt = 0;
  int                        prop_fail_cnt;

  l2_dbg_top i_l2_dbg_top (
    .rclk(rclk), .rst_n(rst_n), .dbg_mode(dbg_mode),
    .bank_evt_0(evt[0]), .bank_addr_0(addr[0]), .bank_hit_0(hit[0]),
    .bank_evt_1(evt[1]), .bank_addr_1(addr[1]), .bank_hit_1(hit[1]),
    .bank_evt_2(evt[2]), .bank_addr_2(addr[2]), .bank_hit_2(hit[2]),
    .bank_evt_3(evt[3]), .bank_addr_3(addr[3]), .bank_hit_3(hit[3]),
    .dbg_ack(dbg_ack), .dbg_req(dbg_req), .dbg_data(dbg_data), .dbg_drop_cnt(dbg_drop_cnt)
  );

  initial begin
    rclk = 1'b0;
    forever #(CLK_PERIOD / 2) rclk = ~rclk;
  end

  // One LFSR step per bit taken, each new bit shifted in at the bottom
  function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = st[0] ? ((st >> 1) ^ LFSR_TAPS) : (st >> 1);
      v = {v[30:0], st[0]};
    end
    return v;
  endfunction

  // Bank in 39:38, mode in 37:36, payload in 35:0
  function automatic logic [`L2_DBG_DATA_W-1:0] build_word(input logic [1:0] bank,
      input dbg_mode_e mode, input logic [31:0] a, input logic h, input logic [15:0] c);
    logic [35:0] pay;
    case (mode)
      MODE_ADDR:  pay = {4'b0, a};
      MODE_HIT:   pay = {h, 3'b0, a};
      MODE_COUNT: pay = {20'b0, c};
      default:    pay = '0;
    endcase
    return {bank, mode, pay};
  endfunction

  // One cycle of events on the masked banks, lowest bank set is the survivor
  task automatic fire(input logic [3:0] mask, input bit delivered);
    logic [`L2_DBG_DATA_W-1:0] w [4];
    logic [31:0]               r;
    int                        win;
    win = -1;
    for (int b = 3; b >= 0; b--) begin
      evt[b] = mask[b];
      addr[b] = take_bits(stim_lfsr, 32);
      r = take_bits(stim_lfsr, 1);
      hit[b] = r[0];
      if (mask[b]) begin
        if (dbg_mode != MODE_OFF && bank_cnt[b] != '1) begin
          bank_cnt[b] = bank_cnt[b] + 1'b1;
        end
        w[b] = build_word(2'(b), dbg_mode, addr[b], hit[b], bank_cnt[b]);
        win = b;
      end
    end
    if (delivered && win >= 0 && dbg_mode != MODE_OFF) begin
      exp_q.push_back(w[win]);
    end
    @(posedge rclk);
    #DRV_DLY;
    evt = '0;
  endtask

  // Edges until dbg_req is seen high
  task automatic wait_req(output int edges);
    edges = 0;
    do begin
      @(posedge rclk);
      #DRV_DLY;
      edges++;
    end while (!dbg_req && edges < 20);
    assert (dbg_req) else begin
      other_err_cnt++;
      $display("[%s] dbg_req did not rise within 20 cycles", test_name);
    end
  endtask

  // Handshake finished, plus one edge for the capture FSM to reach idle
  task automatic wait_idle();
    int n;
    n = 0;
    while ((dbg_req || dbg_ack) && n < 20) begin
      @(posedge rclk);
      #DRV_DLY;
      n++;
    end
    assert (!dbg_req && !dbg_ack) else begin
      other_err_cnt++;
      $display("[%s] handshake did not complete within 20 cycles", test_name);
    end
    @(posedge rclk);
    #DRV_DLY;
  endtask

  // Host side, random 0-3 cycle delay on each phase
  initial begin : host_responder
    logic [31:0]               dly;
    logic [`L2_DBG_DATA_W-1:0] exp_w;
    dbg_ack = 1'b0;
    forever begin
      @(posedge rclk);
      #DRV_DLY;
      if (dbg_req && !dbg_ack) begin
        dly = take_bits(host_lfsr, 2);
        repeat (dly) begin
          @(posedge rclk);
          #DRV_DLY;
        end
        assert (exp_q.size() > 0) else begin
          other_err_cnt++;
          $display("[%s] host received word %h that no event should produce",
                   test_name, dbg_data);
        end
        if (exp_q.size() > 0) begin
          exp_w = exp_q.pop_front();
          assert (dbg_data == exp_w) else begin
            mismatch_cnt++;
            $display("Mismatch in %s: expected %h, actual %h", test_name, exp_w, dbg_data);
          end
        end
        dbg_ack <= 1'b1;
        do begin
          @(posedge rclk);
          #DRV_DLY;
        end while (dbg_req);
        dly = take_bits(host_lfsr, 2);
        repeat (dly) begin
          @(posedge rclk);
          #DRV_DLY;
        end
        dbg_ack <= 1'b0;
      end
    end
  end

  initial begin : stimulus
    int          edges;
    int          drop0;
    logic [31:0] r;
    rst_n = 1'b0;
    dbg_mode = MODE_OFF;
    evt = '0;
    hit = '0;
    for (int b = 0; b < 4; b++) begin
      addr[b] = '0;
    end
    repeat (RST_CYCLES) @(posedge rclk);
    #DRV_DLY;
    rst_n = 1'b1;
    @(posedge rclk);
    #DRV_DLY;
    assert (!dbg_req && dbg_drop_cnt == '0) else begin
      other_err_cnt++;
      $display("[%s] dbg_req or dbg_drop_cnt not cleared by reset", test_name);
    end

    // Fresh counter on one bank, payloads 1, 2, 3 ...
    test_name = "counter_mode";
    dbg_mode = MODE_COUNT;
    r = take_bits(stim_lfsr, 2);
    repeat (N_COUNT) begin
      fire(4'b0001 << r[1:0], 1'b1);
      wait_req(edges);
      wait_idle();
    end

    // Each bank in each tracing mode, path latency four edges
    test_name = "single_event";
    for (int m = 1; m < 4; m++) begin
      for (int b = 0; b < 4; b++) begin
        dbg_mode = dbg_mode_e'(m);
        fire(4'b0001 << b, 1'b1);
        wait_req(edges);
        assert (edges + 1 == 4) else begin
          mismatch_cnt++;
          $display("Mismatch in %s: expected 4 edges to dbg_req, actual %0d",
                   test_name, edges + 1);
        end
        wait_idle();
      end
    end

    test_name = "mode_off";
    dbg_mode = MODE_OFF;
    drop0 = dbg_drop_cnt;
    repeat (OFF_CYC) begin
      r = take_bits(stim_lfsr, 4);
      fire(r[3:0], 1'b1);
      assert (!dbg_req) else begin
        other_err_cnt++;
        $display("[%s] dbg_req rose with tracing off", test_name);
      end
    end
    assert (dbg_drop_cnt == 16'(drop0)) else begin
      mismatch_cnt++;
      $display("Mismatch in %s: expected %0d, actual %0d", test_name, drop0, dbg_drop_cnt);
    end

    // Same-cycle events, only the lowest bank survives, nothing counted as a drop
    test_name = "priority";
    dbg_mode = MODE_HIT;
    for (int i = 0; i < N_PRIO; i++) begin
      drop0 = dbg_drop_cnt;
      fire(PRIO_MASKS[i], 1'b1);
      wait_req(edges);
      wait_idle();
      assert (dbg_drop_cnt == 16'(drop0)) else begin
        mismatch_cnt++;
        $display("Mismatch in %s: expected %0d, actual %0d", test_name, drop0, dbg_drop_cnt);
      end
    end

    // Two followers reach the root while the first word is in CAP_REQ and CAP_REL
    test_name = "back_pressure";
    dbg_mode = MODE_ADDR;
    drop0 = dbg_drop_cnt;
    repeat (N_BURST) begin
      r = take_bits(stim_lfsr, 6);
      fire(4'b0001 << r[1:0], 1'b1);
      fire(4'b0001 << r[3:2], 1'b0);
      fire(4'b0001 << r[5:4], 1'b0);
      wait_req(edges);
      wait_idle();
    end
    assert (dbg_drop_cnt == 16'(drop0 + 2 * N_BURST)) else begin
      mismatch_cnt++;
      $display("Mismatch in %s: expected %0d, actual %0d",
               test_name, drop0 + 2 * N_BURST, dbg_drop_cnt);
    end

    test_name = "end_of_run";
    assert (exp_q.size() == 0) else begin
      other_err_cnt++;
      $display("[%s] %0d expected words never reached the host", test_name, exp_q.size());
    end
    prop_fail_cnt = i_l2_dbg_top.i_l2_dbg_props.fail_cnt;
    $display("Summary: %0d mismatches, %0d other errors, %0d property failures",
             mismatch_cnt, other_err_cnt, prop_fail_cnt);
    if (mismatch_cnt + other_err_cnt + prop_fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WDOG_NS);
    $display("Watchdog expired after %0d ns with the tests still running", WDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule

//--- l2_dbg.f
+incdir+hdl
hdl/l2_dbg_pkg.sv
hdl/dbg_word_fmt.sv
hdl/dbg_rptr.sv
hdl/dbg_capture.sv
hdl/l2_dbg_top.sv
bench/l2_dbg_properties.sv
bench/l2_dbg_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the L2 debug-bus testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module l2_dbg_tb \
  -f l2_dbg.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vl2_dbg_tb +verilator+error+limit+1000 > sim.log 2>&1 ||
  echo "Simulator returned a non-zero status"
cat sim.log
grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } ||
  { echo "Simulation passed"; exit 0; }
